/* Makefile */
TOP = tb_mouse_cursor

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee run.log
	@if grep -q "Finished with errors" run.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "Finished with no errors" run.log; then \
		echo "simulation ended before the final report"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir run.log

/* common/cursor_pkg.sv */
package cursor_pkg;

        typedef logic [10:0] coord_t;

        // 4 bits per channel, r g b from the top
        typedef logic [11:0] rgb_t;

        typedef struct packed {
                logic left;
                logic right;
                logic middle;
        } button_set_t;

        typedef struct packed {
                coord_t      x;
                coord_t      y;
                button_set_t buttons;
        } cursor_state_t;

        localparam rgb_t RGB_IDLE   = 12'hfff;
        localparam rgb_t RGB_LEFT   = 12'hf00;
        localparam rgb_t RGB_RIGHT  = 12'h0f0;
        localparam rgb_t RGB_MIDDLE = 12'h00f;

endpackage

/* common/ps2_pkg.sv */
package ps2_pkg;

        // frame layout: start, eight data bits LSB first, odd parity, stop
        localparam int PS2_DATA_BITS = 8;

        typedef logic [7:0] ps2_byte_t;

        // position of the receiver inside the data bits of a frame
        typedef logic [3:0] ps2_bitcnt_t;

        // sign bit from byte 0 on top of the magnitude byte
        typedef logic signed [8:0] ps2_delta_t;

        typedef struct packed {
                logic       btn_left;
                logic       btn_right;
                logic       btn_middle;
                logic       x_ovf;
                logic       y_ovf;
                ps2_delta_t dx;
                ps2_delta_t dy;
        } mouse_packet_t;

endpackage

/* hdl/button_tracker.sv */
`timescale 1ns/10ps

module button_tracker import ps2_pkg::*, cursor_pkg::*; (
        input  logic          clk,
        input  logic          rstn,
        input  logic          pkt_valid,
        input  mouse_packet_t pkt,
        output button_set_t   buttons,
        output button_set_t   button_press
);

        button_set_t new_levels;

        always_comb begin
                new_levels.left   = pkt.btn_left;
                new_levels.right  = pkt.btn_right;
                new_levels.middle = pkt.btn_middle;
        end

        always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                        buttons      <= '0;
                        button_press <= '0;
                end else if (pkt_valid) begin
                        buttons      <= new_levels;
                        // rising level only, one cycle
                        button_press <= new_levels & ~buttons;
                end else begin
                        button_press <= '0;
                end
        end

endmodule

/* hdl/cursor_motion.sv */
`timescale 1ns/10ps

module cursor_motion import ps2_pkg::*, cursor_pkg::*; #(
        parameter int SCREEN_W = 640,
        parameter int SCREEN_H = 480
) (
        input  logic          clk,
        input  logic          rstn,
        input  logic          pkt_valid,
        input  mouse_packet_t pkt,
        output coord_t        cursor_x,
        output coord_t        cursor_y
);

        // wide enough for coordinate plus or minus a full delta
        typedef logic signed [12:0] wide_t;

        localparam wide_t X_MAX = wide_t'(SCREEN_W - 1);
        localparam wide_t Y_MAX = wide_t'(SCREEN_H - 1);

        wide_t dx_eff;
        wide_t dy_eff;
        wide_t x_next;
        wide_t y_next;

        function automatic coord_t clamp(input wide_t value, input wide_t max_val);
                coord_t result;
                if (value < 0) begin
                        result = '0;
                end else if (value > max_val) begin
                        result = coord_t'(max_val);
                end else begin
                        result = coord_t'(value);
                end
                return result;
        endfunction

        always_comb begin
                // overflowed axis does not move
                dx_eff = pkt.x_ovf ? '0 : wide_t'({{4{pkt.dx[8]}}, pkt.dx});
                dy_eff = pkt.y_ovf ? '0 : wide_t'({{4{pkt.dy[8]}}, pkt.dy});
                x_next = $signed({2'b00, cursor_x}) + dx_eff;
                // mouse y is up, screen y is down
                y_next = $signed({2'b00, cursor_y}) - dy_eff;
        end

        always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                        cursor_x <= coord_t'(SCREEN_W / 2);
                        cursor_y <= coord_t'(SCREEN_H / 2);
                end else if (pkt_valid) begin
                        cursor_x <= clamp(x_next, X_MAX);
                        cursor_y <= clamp(y_next, Y_MAX);
                end
        end

endmodule

/* hdl/cursor_overlay.sv */
`timescale 1ns/10ps

module cursor_overlay import cursor_pkg::*; #(
        parameter int SCREEN_W    = 640,
        parameter int SCREEN_H    = 480,
        parameter int CURSOR_SIZE = 8
) (
        input  logic          clk,
        input  logic          rstn,
        input  coord_t        pixel_x,
        input  coord_t        pixel_y,
        input  cursor_state_t cursor,
        output logic          cursor_hit,
        output rgb_t          cursor_rgb
);

        logic [11:0] x_end;
        logic [11:0] y_end;
        logic        in_x;
        logic        in_y;
        logic        on_screen;
        rgb_t        rgb_next;

        // one past the last cursor pixel, kept a bit wider than coord_t
        assign x_end = {1'b0, cursor.x} + 12'(CURSOR_SIZE);
        assign y_end = {1'b0, cursor.y} + 12'(CURSOR_SIZE);

        assign in_x      = (pixel_x >= cursor.x) && ({1'b0, pixel_x} < x_end);
        assign in_y      = (pixel_y >= cursor.y) && ({1'b0, pixel_y} < y_end);
        // square is cut at the screen edge
        assign on_screen = (pixel_x < coord_t'(SCREEN_W)) && (pixel_y < coord_t'(SCREEN_H));

        always_comb begin
                if (cursor.buttons.left) begin
                        rgb_next = RGB_LEFT;
                end else if (cursor.buttons.right) begin
                        rgb_next = RGB_RIGHT;
                end else if (cursor.buttons.middle) begin
                        rgb_next = RGB_MIDDLE;
                end else begin
                        rgb_next = RGB_IDLE;
                end
        end

        always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                        cursor_hit <= 1'b0;
                end else begin
                        cursor_hit <= in_x & in_y & on_screen;
                end
        end

        always_ff @(posedge clk) begin
                cursor_rgb <= rgb_next;
        end

endmodule

/* hdl/mouse_cursor_top.sv */
`timescale 1ns/10ps

module mouse_cursor_top import ps2_pkg::*, cursor_pkg::*; #(
        parameter int SCREEN_W    = 640,
        parameter int SCREEN_H    = 480,
        parameter int CURSOR_SIZE = 8
) (
        input  logic        clk,
        input  logic        rstn,
        input  logic        enable,
        input  logic        ps2_clk,
        input  logic        ps2_data,
        input  coord_t      pixel_x,
        input  coord_t      pixel_y,
        output logic        packet_valid,
        output logic        frame_error,
        output coord_t      cursor_x,
        output coord_t      cursor_y,
        output button_set_t buttons,
        output button_set_t button_press,
        output logic        cursor_hit,
        output rgb_t        cursor_rgb
);

        logic          byte_valid;
        ps2_byte_t     rx_byte;
        mouse_packet_t pkt;
        cursor_state_t cursor;

        assign cursor = '{x: cursor_x, y: cursor_y, buttons: buttons};

        ps2_frame_rx u_frame_rx (
                .clk         (clk),
                .rstn        (rstn),
                .enable      (enable),
                .ps2_clk     (ps2_clk),
                .ps2_data    (ps2_data),
                .byte_valid  (byte_valid),
                .rx_byte     (rx_byte),
                .frame_error (frame_error)
        );

        ps2_packet_asm u_packet_asm (
                .clk         (clk),
                .rstn        (rstn),
                .byte_valid  (byte_valid),
                .frame_error (frame_error),
                .rx_byte     (rx_byte),
                .pkt_valid   (packet_valid),
                .pkt         (pkt)
        );

        cursor_motion #(
                .SCREEN_W (SCREEN_W),
                .SCREEN_H (SCREEN_H)
        ) u_motion (
                .clk       (clk),
                .rstn      (rstn),
                .pkt_valid (packet_valid),
                .pkt       (pkt),
                .cursor_x  (cursor_x),
                .cursor_y  (cursor_y)
        );

        button_tracker u_buttons (
                .clk          (clk),
                .rstn         (rstn),
                .pkt_valid    (packet_valid),
                .pkt          (pkt),
                .buttons      (buttons),
                .button_press (button_press)
        );

        cursor_overlay #(
                .SCREEN_W    (SCREEN_W),
                .SCREEN_H    (SCREEN_H),
                .CURSOR_SIZE (CURSOR_SIZE)
        ) u_overlay (
                .clk        (clk),
                .rstn       (rstn),
                .pixel_x    (pixel_x),
                .pixel_y    (pixel_y),
                .cursor     (cursor),
                .cursor_hit (cursor_hit),
                .cursor_rgb (cursor_rgb)
        );

endmodule

/* ps2_rx/ps2_frame_rx.sv */
`timescale 1ns/10ps

module ps2_frame_rx import ps2_pkg::*; (
        input  logic      clk,
        input  logic      rstn,
        input  logic      enable,
        input  logic      ps2_clk,
        input  logic      ps2_data,
        output logic      byte_valid,
        output ps2_byte_t rx_byte,
        output logic      frame_error
);

        typedef enum logic [1:0] {
                RX_IDLE,
                RX_DATA,
                RX_PARITY,
                RX_STOP
        } rx_state_e;

        localparam ps2_bitcnt_t BIT_LAST = ps2_bitcnt_t'(PS2_DATA_BITS - 1);

        rx_state_e   state;
        logic [1:0]  clk_sync;
        logic        clk_prev;
        logic        clk_fall;
        logic [2:0]  data_sync;
        logic        data_bit;
        ps2_bitcnt_t bit_cnt;
        ps2_byte_t   shift_reg;
        logic        parity_bit;
        logic        frame_ok;

        // both lines idle high; data gets a third stage to line up with clk_fall
        always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                        clk_sync  <= 2'b11;
                        clk_prev  <= 1'b1;
                        clk_fall  <= 1'b0;
                        data_sync <= 3'b111;
                end else begin
                        clk_sync  <= {clk_sync[0], ps2_clk};
                        clk_prev  <= clk_sync[1];
                        clk_fall  <= clk_prev & ~clk_sync[1];
                        data_sync <= {data_sync[1:0], ps2_data};
                end
        end

        assign data_bit = data_sync[2];

        // odd parity over data plus parity bit, and stop must be high
        assign frame_ok = (^{shift_reg, parity_bit}) & data_bit;

        always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                        state       <= RX_IDLE;
                        bit_cnt     <= '0;
                        byte_valid  <= 1'b0;
                        frame_error <= 1'b0;
                end else begin
                        byte_valid  <= 1'b0;
                        frame_error <= 1'b0;
                        if (!enable) begin
                                // partial frame is dropped
                                state <= RX_IDLE;
                        end else if (clk_fall) begin
                                case (state)
                                RX_IDLE: begin
                                        if (!data_bit) begin
                                                state   <= RX_DATA;
                                                bit_cnt <= '0;
                                        end
                                end
                                RX_DATA: begin
                                        bit_cnt <= bit_cnt + 1'b1;
                                        if (bit_cnt == BIT_LAST) begin
                                                state <= RX_PARITY;
                                        end
                                end
                                RX_PARITY: begin
                                        state <= RX_STOP;
                                end
                                RX_STOP: begin
                                        state       <= RX_IDLE;
                                        byte_valid  <= frame_ok;
                                        frame_error <= ~frame_ok;
                                end
                                default: begin
                                        state <= RX_IDLE;
                                end
                                endcase
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (clk_fall) begin
                        if (state == RX_DATA) begin
                                shift_reg <= {data_bit, shift_reg[7:1]};
                        end
                        if (state == RX_PARITY) begin
                                parity_bit <= data_bit;
                        end
                end
                if (enable && clk_fall && state == RX_STOP) begin
                        rx_byte <= shift_reg;
                end
        end

endmodule

/* ps2_rx/ps2_packet_asm.sv */
`timescale 1ns/10ps

module ps2_packet_asm import ps2_pkg::*; (
        input  logic          clk,
        input  logic          rstn,
        input  logic          byte_valid,
        input  logic          frame_error,
        input  ps2_byte_t     rx_byte,
        output logic          pkt_valid,
        output mouse_packet_t pkt
);

        typedef enum logic [1:0] {
                ASM_BYTE0,
                ASM_BYTE1,
                ASM_BYTE2
        } asm_state_e;

        asm_state_e state;
        ps2_byte_t  head;
        ps2_byte_t  x_mag;

        always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                        state     <= ASM_BYTE0;
                        pkt_valid <= 1'b0;
                end else begin
                        pkt_valid <= 1'b0;
                        if (frame_error) begin
                                state <= ASM_BYTE0;
                        end else if (byte_valid) begin
                                case (state)
                                ASM_BYTE0: begin
                                        // bit 3 is always one in a real first byte
                                        if (rx_byte[3]) begin
                                                state <= ASM_BYTE1;
                                        end
                                end
                                ASM_BYTE1: begin
                                        state <= ASM_BYTE2;
                                end
                                ASM_BYTE2: begin
                                        state     <= ASM_BYTE0;
                                        pkt_valid <= 1'b1;
                                end
                                default: begin
                                        state <= ASM_BYTE0;
                                end
                                endcase
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (byte_valid) begin
                        case (state)
                        ASM_BYTE0: head <= rx_byte;
                        ASM_BYTE1: x_mag <= rx_byte;
                        ASM_BYTE2: begin
                                pkt <= '{btn_left:   head[0],
                                         btn_right:  head[1],
                                         btn_middle: head[2],
                                         x_ovf:      head[6],
                                         y_ovf:      head[7],
                                         dx:         {head[4], x_mag},
                                         dy:         {head[5], rx_byte}};
                        end
                        default: ;
                        endcase
                end
        end

endmodule

/* testbench/mouse_cursor_asserts.sv */
`timescale 1ns/10ps

module mouse_cursor_asserts import cursor_pkg::*; #(
        parameter int SCREEN_W = 640,
        parameter int SCREEN_H = 480
) (
        input logic   clk,
        input logic   rstn,
        input logic   packet_valid,
        input logic   frame_error,
        input coord_t cursor_x,
        input coord_t cursor_y
);

        // packet strobe lasts one cycle
        a_single_pulse: assert property (@(posedge clk) disable iff (!rstn)
                packet_valid |=> !packet_valid)
                else $error("packet_valid stayed high for more than one cycle");

        a_on_screen: assert property (@(posedge clk) disable iff (!rstn)
                (cursor_x < SCREEN_W) && (cursor_y < SCREEN_H))
                else $error("cursor position left the screen");

        a_no_overlap: assert property (@(posedge clk) disable iff (!rstn)
                !(packet_valid && frame_error))
                else $error("packet_valid and frame_error high together");

endmodule

bind mouse_cursor_top mouse_cursor_asserts #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
) u_asserts (
        .clk          (clk),
        .rstn         (rstn),
        .packet_valid (packet_valid),
        .frame_error  (frame_error),
        .cursor_x     (cursor_x),
        .cursor_y     (cursor_y)
);

/* testbench/tb_mouse_cursor.sv */
`timescale 1ns/10ps

module tb_mouse_cursor import cursor_pkg::*; ();

        localparam int SCREEN_W     = 640;
        localparam int SCREEN_H     = 480;
        localparam int CURSOR_SIZE  = 8;
        localparam int HALF         = 20;
        localparam int NUM          = 18;
        // eleven bits of two half periods plus the longest idle gap
        localparam int FRAME_CYCLES = 22 * HALF + 20;
        localparam int WATCHDOG_NS  = NUM * FRAME_CYCLES * 4 * 8;

        // how an entry goes out on the line
        localparam logic [1:0] M_OK     = 2'd0;
        localparam logic [1:0] M_PARITY = 2'd1;
        localparam logic [1:0] M_OFF    = 2'd2;
        localparam logic [1:0] M_SKIP   = 2'd3;

        typedef struct packed {
                logic [23:0] bytes;
                logic [1:0]  mode;
                coord_t      x;
                coord_t      y;
                logic [2:0]  btn;
                logic [2:0]  press;
                coord_t      px;
                coord_t      py;
                logic        hit;
                rgb_t        rgb;
        } entry_t;

        logic        clk = 1'b0;
        logic        rstn;
        logic        enable;
        logic        ps2_clk;
        logic        ps2_data;
        coord_t      pixel_x;
        coord_t      pixel_y;
        logic        packet_valid;
        logic        frame_error;
        coord_t      cursor_x;
        coord_t      cursor_y;
        button_set_t buttons;
        button_set_t button_press;
        logic        cursor_hit;
        rgb_t        cursor_rgb;

        entry_t      tbl [NUM];
        int          errors = 0;
        int          pkt_count = 0;
        int          err_count = 0;
        logic        valid_d = 1'b0;
        logic [2:0]  press_seen = '0;
        integer      seed = 32'h5b91f4ec;

        mouse_cursor_top #(
                .SCREEN_W    (SCREEN_W),
                .SCREEN_H    (SCREEN_H),
                .CURSOR_SIZE (CURSOR_SIZE)
        ) DUT (
                .clk          (clk),
                .rstn         (rstn),
                .enable       (enable),
                .ps2_clk      (ps2_clk),
                .ps2_data     (ps2_data),
                .pixel_x      (pixel_x),
                .pixel_y      (pixel_y),
                .packet_valid (packet_valid),
                .frame_error  (frame_error),
                .cursor_x     (cursor_x),
                .cursor_y     (cursor_y),
                .buttons      (buttons),
                .button_press (button_press),
                .cursor_hit   (cursor_hit),
                .cursor_rgb   (cursor_rgb)
        );

        always #4 clk = ~clk;

        // strobes counted mid-cycle and the press pulse taken the cycle after packet_valid
        always @(negedge clk) begin
                if (packet_valid) pkt_count <= pkt_count + 1;
                if (frame_error) err_count <= err_count + 1;
                if (valid_d) press_seen <= button_press;
                valid_d <= packet_valid;
        end

        task automatic step(input int n);
                repeat (n) @(posedge clk);
                #1;
        endtask

        task automatic report_mismatch(input string name, input int got, input int want);
                $display("** Error at time %0t: %s is %0d, expected %0d", $time, name, got, want);
                errors++;
        endtask

        task automatic report_failure(input string what);
                $display("** Error at time %0t: %s", $time, what);
                errors++;
        endtask

        // plays the mouse side of one frame with data changing while ps2_clk is high
        task automatic send_frame(input logic [7:0] data, input logic bad_parity);
                logic [10:0] bits;
                int          i;
                bits = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};
                for (i = 0; i < 11; i++) begin
                        ps2_data = bits[i];
                        step(HALF);
                        ps2_clk = 1'b0;
                        step(HALF);
                        ps2_clk = 1'b1;
                end
                step(4 + ($random(seed) & 15));
        endtask

        task automatic wait_for_event(input int pkt_base, input int err_base);
                int n;
                n = 0;
                while (pkt_count == pkt_base && err_count == err_base && n < 4 * HALF) begin
                        @(negedge clk);
                        n++;
                end
                if (pkt_count == pkt_base && err_count == err_base)
                        report_failure("no packet_valid or frame_error after the frames");
        endtask

        initial begin
                #(WATCHDOG_NS);
                $display("** Error at time %0t: watchdog expired, run did not finish", $time);
                $display("Finished with errors");
                $finish;
        end

        initial begin
                entry_t e;
                int     i;
                int     pkt_base;
                int     err_base;
                logic   expect_pkt;
                // bytes, mode, x, y, buttons, press, probe x, probe y, hit, colour
                tbl[0]  = '{24'h080a05, M_OK, 330, 235, 3'b000, 3'b000, 330, 235, 1, 12'hfff};
                tbl[1]  = '{24'h39ecf1, M_OK, 310, 250, 3'b100, 3'b100, 317, 257, 1, 12'hf00};
                tbl[2]  = '{24'h0b0000, M_OK, 310, 250, 3'b110, 3'b010, 318, 250, 0, 12'hf00};
                tbl[3]  = '{24'h0c0000, M_OK, 310, 250, 3'b001, 3'b001, 309, 250, 0, 12'h00f};
                tbl[4]  = '{24'h0e0000, M_OK, 310, 250, 3'b011, 3'b010, 310, 249, 0, 12'h0f0};
                tbl[5]  = '{24'h08ff00, M_OK, 565, 250, 3'b000, 3'b000, 565, 250, 1, 12'hfff};
                tbl[6]  = '{24'h08ff00, M_OK, 639, 250, 3'b000, 3'b000, 639, 250, 1, 12'hfff};
                tbl[7]  = '{24'h0800ff, M_OK, 639, 0, 3'b000, 3'b000, 640, 0, 0, 12'hfff};
                tbl[8]  = '{24'h380000, M_OK, 383, 256, 3'b000, 3'b000, 390, 263, 1, 12'hfff};
                tbl[9]  = '{24'h380000, M_OK, 127, 479, 3'b000, 3'b000, 126, 479, 0, 12'hfff};
                tbl[10] = '{24'h380000, M_OK, 0, 479, 3'b000, 3'b000, 7, 479, 1, 12'hfff};
                tbl[11] = '{24'h485010, M_OK, 0, 463, 3'b000, 3'b000, 0, 463, 1, 12'hfff};
                tbl[12] = '{24'h882040, M_OK, 32, 463, 3'b000, 3'b000, 40, 463, 0, 12'hfff};
                tbl[13] = '{24'h090502, M_PARITY, 32, 463, 3'b000, 3'b000, 39, 470, 1, 12'hfff};
                tbl[14] = '{24'h090803, M_OK, 40, 460, 3'b100, 3'b100, 40, 460, 1, 12'hf00};
                tbl[15] = '{24'h081000, M_SKIP, 56, 460, 3'b000, 3'b000, 63, 467, 1, 12'hfff};
                tbl[16] = '{24'h094040, M_OFF, 56, 460, 3'b000, 3'b000, 64, 460, 0, 12'hfff};
                tbl[17] = '{24'h2a04fc, M_OK, 60, 464, 3'b010, 3'b010, 60, 471, 1, 12'h0f0};

                rstn     = 1'b0;
                enable   = 1'b1;
                ps2_clk  = 1'b1;
                ps2_data = 1'b1;
                pixel_x  = '0;
                pixel_y  = '0;
                step(8);
                rstn = 1'b1;
                step(4);
                @(negedge clk);
                // centre of a 640 by 480 screen
                if (cursor_x !== 11'd320) report_mismatch("cursor_x", cursor_x, 320);
                if (cursor_y !== 11'd240) report_mismatch("cursor_y", cursor_y, 240);
                step(1);

                for (i = 0; i < NUM; i++) begin
                        e          = tbl[i];
                        pkt_base   = pkt_count;
                        err_base   = err_count;
                        expect_pkt = (e.mode == M_OK) || (e.mode == M_SKIP);
                        enable     = (e.mode != M_OFF);
                        // stray byte with bit 3 clear ahead of the packet
                        if (e.mode == M_SKIP) send_frame(8'h01, 1'b0);
                        send_frame(e.bytes[23:16], e.mode == M_PARITY);
                        send_frame(e.bytes[15:8], 1'b0);
                        send_frame(e.bytes[7:0], 1'b0);
                        enable = 1'b1;
                        if (e.mode != M_OFF) wait_for_event(pkt_base, err_base);
                        @(negedge clk);
                        if ((pkt_count - pkt_base) != (expect_pkt ? 1 : 0))
                                report_mismatch("packet_valid count", pkt_count - pkt_base,
                                                expect_pkt);
                        if ((err_count - err_base) != ((e.mode == M_PARITY) ? 1 : 0))
                                report_mismatch("frame_error count", err_count - err_base,
                                                e.mode == M_PARITY);
                        if (cursor_x !== e.x) report_mismatch("cursor_x", cursor_x, e.x);
                        if (cursor_y !== e.y) report_mismatch("cursor_y", cursor_y, e.y);
                        if (buttons !== e.btn) report_mismatch("buttons", buttons, e.btn);
                        if (expect_pkt && press_seen !== e.press)
                                report_mismatch("button_press", press_seen, e.press);
                        // press pulse is over by now
                        if (button_press !== 3'b000)
                                report_mismatch("button_press", button_press, 0);

                        // overlay output is registered one cycle after the probe
                        step(1);
                        pixel_x = e.px;
                        pixel_y = e.py;
                        @(posedge clk);
                        @(negedge clk);
                        if (cursor_hit !== e.hit) report_mismatch("cursor_hit", cursor_hit, e.hit);
                        if (cursor_rgb !== e.rgb) report_mismatch("cursor_rgb", cursor_rgb, e.rgb);
                        step(1);
                end

                $display("errors: %0d, table entries applied: %0d", errors, NUM);
                if (errors == 0) begin
                        $display("Finished with no errors");
                end else begin
                        $display("Finished with errors");
                end
                $finish;
        end

endmodule

/* vlog.f */
common/ps2_pkg.sv
common/cursor_pkg.sv
ps2_rx/ps2_frame_rx.sv
ps2_rx/ps2_packet_asm.sv
hdl/cursor_motion.sv
hdl/button_tracker.sv
hdl/cursor_overlay.sv
hdl/mouse_cursor_top.sv
testbench/mouse_cursor_asserts.sv
testbench/tb_mouse_cursor.sv
